/* source/alu_macros.svh */
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// Width of an integer register and of every result word
`define ALU_XLEN 64

// Tag that travels with each command and comes back with its result
`define ALU_TAG_W 8

// I-type immediate as it sits in the instruction
`define ALU_IMM_W 12

// Shift amount for full width shifts, then for the 32-bit W forms
`define ALU_SHAMT_W 6
`define ALU_SHAMTW_W 5

`endif

/* source/alu_pkg.sv */
`default_nettype none

`include "alu_macros.svh"

package alu_pkg;

    // Plain vector types for the widths used across the datapath
    typedef logic [`ALU_XLEN-1:0] xlen_t;
    typedef logic [`ALU_TAG_W-1:0] tag_t;
    typedef logic signed [`ALU_IMM_W-1:0] imm_t;
    typedef logic [2:0] funct3_t;
    typedef logic [`ALU_SHAMT_W-1:0] shamt_t;
    typedef logic [`ALU_SHAMTW_W-1:0] shamtw_t;
    // A W-form operand is exactly as wide as its shift amount can reach
    typedef logic [(1 << `ALU_SHAMTW_W)-1:0] word_t;

    // RISC-V OP/OP-IMM function codes
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // Operation after decode, one value per ALU function
    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } alu_op_e;

    // Command as it arrives from the issue side
    typedef struct packed {
        tag_t    tag;
        funct3_t funct3;
        logic    alt;
        logic    word;
        logic    use_imm;
        xlen_t   rs1;
        xlen_t   rs2;
        imm_t    imm;
    } alu_cmd_t;

    // Command after operand select and decode
    typedef struct packed {
        tag_t    tag;
        alu_op_e op;
        logic    word;
        xlen_t   opa;
        xlen_t   opb;
    } alu_issued_t;

    typedef struct packed {
        tag_t  tag;
        xlen_t value;
    } alu_result_t;

endpackage

`default_nettype wire

/* source/fifo_2d_fwft.sv */
`timescale 1ns/1ps
`default_nettype none

module fifo_2d_fwft #(
    parameter int WIDTH = 64
) (
    input  wire              clk,
    input  wire              rst,
    input  wire  [WIDTH-1:0] a_data,
    input  wire              a_valid,
    output logic             a_ready,
    output logic [WIDTH-1:0] b_data,
    output logic             b_valid,
    input  wire              b_ready
);

    // Top always holds the oldest entry, bottom the one behind it
    logic [WIDTH-1:0] fifo_top;
    logic [WIDTH-1:0] fifo_bottom;
    logic fifo_empty;
    logic fifo_full;
    logic push;
    logic pop;

    assign push = a_valid && a_ready;
    assign pop = b_valid && b_ready;

    // Occupancy flags, empty and full are never set together
    always_ff @(posedge clk) begin
        if (rst) begin
            fifo_empty <= 1'b1;
            fifo_full <= 1'b0;
        end else if (push && !pop) begin
            // One more entry, cannot happen while full since a_ready is low
            if (fifo_empty)
                fifo_empty <= 1'b0;
            else
                fifo_full <= 1'b1;
        end else if (pop && !push) begin
            // One entry leaves, when empty a pop always comes with a push
            if (fifo_full)
                fifo_full <= 1'b0;
            else
                fifo_empty <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_full) begin
            // Bottom moves up, and a new item can take its place at once
            if (pop) begin
                fifo_top <= fifo_bottom;
                if (push)
                    fifo_bottom <= a_data;
            end
        end else if (push) begin
            // With one entry popping, or when empty, new data lands in top
            // Empty with push and pop is a pass-through, top stays unused
            if (fifo_empty || pop)
                fifo_top <= a_data;
            else
                fifo_bottom <= a_data;
        end
    end

    // Input falls straight through when nothing is buffered
    assign b_valid = !fifo_empty || a_valid;
    assign b_data = fifo_empty ? a_data : fifo_top;

    // Full buffer still accepts when the consumer frees a slot this cycle
    assign a_ready = b_ready || !fifo_full;

endmodule

`default_nettype wire

/* source/alu_issue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module alu_issue import alu_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         alu_cmd_t cmd,
    input  wire         cmd_valid,
    output logic        cmd_ready,
    output alu_issued_t iss,
    output logic        iss_valid,
    input  wire         iss_ready
);

    // Bits added on top of the immediate to reach full width
    localparam int EXT_W = `ALU_XLEN - `ALU_IMM_W;

    alu_op_e dec_op;
    xlen_t imm_ext;
    xlen_t opb_sel;
    logic take;

    // Stage is free when empty or when exec takes the current item
    assign cmd_ready = !iss_valid || iss_ready;
    assign take = cmd_valid && cmd_ready;

    // Decode funct3 and alt into one operation
    always_comb begin
        case (cmd.funct3)
            F3_ADD: begin
                // addi has no subtract form, so alt only counts with rs2
                dec_op = (cmd.alt && !cmd.use_imm) ? SUB : ADD;
            end
            F3_SLL:  dec_op = SLL;
            F3_SLT:  dec_op = SLT;
            F3_SLTU: dec_op = SLTU;
            F3_XOR:  dec_op = XOR;
            F3_SR: begin
                // srai/sraw carry alt the same way as sra
                dec_op = cmd.alt ? SRA : SRL;
            end
            F3_OR:   dec_op = OR;
            F3_AND:  dec_op = AND;
            default: dec_op = ADD;
        endcase
    end

    // Immediate is signed in every form
    assign imm_ext = {{EXT_W{cmd.imm[`ALU_IMM_W-1]}}, cmd.imm};
    assign opb_sel = cmd.use_imm ? imm_ext : cmd.rs2;

    always_ff @(posedge clk) begin
        if (rst) begin
            iss_valid <= 1'b0;
        end else if (take) begin
            iss_valid <= 1'b1;
        end else if (iss_ready) begin
            // Item left for exec and nothing replaced it
            iss_valid <= 1'b0;
        end
    end

    // Payload only loads on a transfer so it holds steady while stalled
    always_ff @(posedge clk) begin
        if (take) begin
            iss.tag <= cmd.tag;
            iss.op <= dec_op;
            iss.word <= cmd.word;
            iss.opa <= cmd.rs1;
            iss.opb <= opb_sel;
        end
    end

endmodule

`default_nettype wire

/* source/alu_exec.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module alu_exec import alu_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         alu_issued_t iss,
    input  wire         iss_valid,
    output logic        iss_ready,
    output alu_result_t res,
    output logic        res_valid,
    input  wire         res_ready
);

    localparam int WORD_W = $bits(word_t);

    // Full width operands and shift amount
    xlen_t a64;
    xlen_t b64;
    shamt_t sh64;
    xlen_t r64;

    // W-form operands, only the low half of each register
    word_t a32;
    word_t b32;
    shamtw_t sh32;
    word_t r32;

    xlen_t value;
    logic take;

    assign iss_ready = !res_valid || res_ready;
    assign take = iss_valid && iss_ready;

    assign a64 = iss.opa;
    assign b64 = iss.opb;
    assign sh64 = b64[`ALU_SHAMT_W-1:0];

    assign a32 = iss.opa[WORD_W-1:0];
    assign b32 = iss.opb[WORD_W-1:0];
    assign sh32 = b32[`ALU_SHAMTW_W-1:0];

    // 64-bit datapath
    always_comb begin
        r64 = '0;
        case (iss.op)
            ADD:  r64 = a64 + b64;
            SUB:  r64 = a64 - b64;
            SLL:  r64 = a64 << sh64;
            SLT:  r64[0] = $signed(a64) < $signed(b64);
            SLTU: r64[0] = a64 < b64;
            XOR:  r64 = a64 ^ b64;
            SRL:  r64 = a64 >> sh64;
            // Arithmetic shift fills from bit 63
            SRA:  r64 = $signed(a64) >>> sh64;
            OR:   r64 = a64 | b64;
            AND:  r64 = a64 & b64;
            default: r64 = a64 + b64;
        endcase
    end

    // 32-bit datapath for W commands, compares are done on 32 bits too
    always_comb begin
        r32 = '0;
        case (iss.op)
            ADD:  r32 = a32 + b32;
            SUB:  r32 = a32 - b32;
            SLL:  r32 = a32 << sh32;
            SLT:  r32[0] = $signed(a32) < $signed(b32);
            SLTU: r32[0] = a32 < b32;
            XOR:  r32 = a32 ^ b32;
            SRL:  r32 = a32 >> sh32;
            // Sign comes from bit 31 here, not from the upper half
            SRA:  r32 = $signed(a32) >>> sh32;
            OR:   r32 = a32 | b32;
            AND:  r32 = a32 & b32;
            default: r32 = a32 + b32;
        endcase
    end

    // W results are sign-extended to the full register width
    assign value = iss.word ? {{(`ALU_XLEN-WORD_W){r32[WORD_W-1]}}, r32} : r64;

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else if (take) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    // Result and tag are captured together on each transfer
    always_ff @(posedge clk) begin
        if (take) begin
            res.tag <= iss.tag;
            res.value <= value;
        end
    end

endmodule

`default_nettype wire

/* source/alu_pipe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_pipe_top import alu_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         alu_cmd_t in_cmd,
    input  wire         in_valid,
    output logic        in_ready,
    output alu_result_t out_res,
    output logic        out_valid,
    input  wire         out_ready
);

    // Input buffer to issue
    alu_cmd_t cmd;
    logic cmd_valid;
    logic cmd_ready;

    // Issue to execute
    alu_issued_t iss;
    logic iss_valid;
    logic iss_ready;

    // Execute to output buffer
    alu_result_t res;
    logic res_valid;
    logic res_ready;

    // Absorbs stalls from issue so the upstream sees ready for longer
    fifo_2d_fwft #(
        .WIDTH($bits(alu_cmd_t))
    ) in_fifo (
        .clk(clk),
        .rst(rst),
        .a_data(in_cmd),
        .a_valid(in_valid),
        .a_ready(in_ready),
        .b_data(cmd),
        .b_valid(cmd_valid),
        .b_ready(cmd_ready)
    );

    alu_issue u_issue (
        .clk(clk),
        .rst(rst),
        .cmd(cmd),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .iss(iss),
        .iss_valid(iss_valid),
        .iss_ready(iss_ready)
    );

    alu_exec u_exec (
        .clk(clk),
        .rst(rst),
        .iss(iss),
        .iss_valid(iss_valid),
        .iss_ready(iss_ready),
        .res(res),
        .res_valid(res_valid),
        .res_ready(res_ready)
    );

    // Keeps the execute register moving while the consumer stalls
    fifo_2d_fwft #(
        .WIDTH($bits(alu_result_t))
    ) out_fifo (
        .clk(clk),
        .rst(rst),
        .a_data(res),
        .a_valid(res_valid),
        .a_ready(res_ready),
        .b_data(out_res),
        .b_valid(out_valid),
        .b_ready(out_ready)
    );

endmodule

`default_nettype wire

/* test/alu_pipe_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_pipe_chk import alu_pkg::*; (
    input wire clk,
    input wire rst,
    input wire in_ready,
    input wire out_valid,
    input wire out_ready,
    input wire alu_result_t out_res
);

    // Output stays idle through reset and in the first cycle after it
    a_reset_out_idle: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid was high during reset or right after it");

    // A stalled result must be held with its data until the consumer takes it
    a_hold_while_stalled: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_res)))
        else $error("out_valid or out_res changed while out_ready was low");

    // An empty pipeline accepts a command straight away
    a_ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> in_ready)
        else $error("in_ready was low in the first cycle after reset");

endmodule

bind alu_pipe_top alu_pipe_chk chk (
    .clk(clk),
    .rst(rst),
    .in_ready(in_ready),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_res(out_res)
);

`default_nettype wire

/* test/alu_pipe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "alu_macros.svh"

module alu_pipe_tb import alu_pkg::*; ();

    localparam int TIMEOUT = 200;

    logic clk;
    logic rst;
    alu_cmd_t in_cmd;
    logic in_valid;
    logic in_ready;
    alu_result_t out_res;
    logic out_valid;
    logic out_ready;

    logic [31:0] lcg_state = 32'h8003_5afe;
    logic rand_ready;
    tag_t dir_tag;
    alu_result_t exp_q[$];
    alu_result_t want;
    int errors;
    int accepted;
    int results;

    // Operand pairs with negative values and shift amounts above 31
    xlen_t opa_tab [0:3] = '{64'hfedc_ba98_7654_3210, 64'h8000_0000_0000_0005,
                             64'h0000_0000_0000_0005, 64'h0000_0001_8000_0000};
    xlen_t opb_tab [0:3] = '{64'h0000_0000_0000_0043, 64'hffff_ffff_ffff_fffe,
                             64'hffff_ffff_ffff_fff0, 64'hffff_ffff_ffff_ffe1};
    imm_t imm_tab [0:3] = '{12'h800, 12'h7ff, 12'hfff, 12'h025};

    alu_pipe_top uut (
        .clk(clk),
        .rst(rst),
        .in_cmd(in_cmd),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_res(out_res),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic alu_cmd_t random_cmd();
        alu_cmd_t c;
        logic [31:0] r;
        r = next_rand();
        c.tag = r[31:24];
        c.funct3 = r[2:0];
        c.alt = r[3];
        c.word = r[4];
        c.use_imm = r[5];
        c.imm = r[17:6];
        c.rs1 = {next_rand(), next_rand()};
        c.rs2 = {next_rand(), next_rand()};
        return c;
    endfunction

    // Expected result built straight from the RISC-V operation rules
    function automatic alu_result_t alu_ref(input alu_cmd_t c);
        alu_result_t r;
        xlen_t a;
        xlen_t b;
        xlen_t v;
        logic [5:0] sh;
        b = c.use_imm ? {{52{c.imm[11]}}, c.imm} : c.rs2;
        a = c.rs1;
        sh = b[5:0];
        if (c.word) begin
            // Sign extending both low words keeps signed and unsigned order intact
            a = {{32{a[31]}}, a[31:0]};
            b = {{32{b[31]}}, b[31:0]};
            sh[5] = 1'b0;
        end
        case (c.funct3)
            3'd0: v = (c.alt && !c.use_imm) ? a - b : a + b;
            3'd1: v = a << sh;
            3'd2: v = {63'd0, $signed(a) < $signed(b)};
            3'd3: v = {63'd0, a < b};
            3'd4: v = a ^ b;
            3'd5: begin
                // A logical W shift must pull in zeros above bit 31
                if (c.alt)
                    v = (a >> sh) | (a[63] ? ~({64{1'b1}} >> sh) : 64'd0);
                else if (c.word)
                    v = {32'd0, a[31:0]} >> sh;
                else
                    v = a >> sh;
            end
            3'd6: v = a | b;
            default: v = a & b;
        endcase
        if (c.word)
            v = {{32{v[31]}}, v[31:0]};
        r.tag = c.tag;
        r.value = v;
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        $display("Run stopped: %0d errors, %0d results returned for %0d commands",
                 errors + 1, results, accepted);
        $display("TEST FAIL");
        $finish;
    endtask

    // Moves to the next drive point, with a fresh random out_ready when enabled
    task automatic tick();
        logic [31:0] r;
        @(posedge clk);
        #1;
        if (rand_ready) begin
            r = next_rand();
            out_ready = r[9];
        end
    endtask

    // Offers one command and holds it until the DUT takes it
    task automatic send_cmd(input alu_cmd_t c);
        int waited;
        logic done;
        waited = 0;
        done = 1'b0;
        in_cmd = c;
        in_valid = 1'b1;
        while (!done) begin
            @(negedge clk);
            done = in_ready;
            tick();
            waited++;
            if (!done && waited > TIMEOUT)
                stop_on_timeout("acceptance of a command");
        end
        in_valid = 1'b0;
    endtask

    task automatic send_directed(input funct3_t f3, input logic alt, input logic word,
                                 input logic use_imm, input xlen_t rs1, input xlen_t rs2,
                                 input imm_t imm);
        alu_cmd_t c;
        c.tag = dir_tag;
        c.funct3 = f3;
        c.alt = alt;
        c.word = word;
        c.use_imm = use_imm;
        c.rs1 = rs1;
        c.rs2 = rs2;
        c.imm = imm;
        dir_tag = dir_tag + 8'd1;
        send_cmd(c);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        rand_ready = 1'b0;
        out_ready = 1'b1;
        while (exp_q.size() != 0) begin
            tick();
            waited++;
            if (waited > TIMEOUT)
                stop_on_timeout("return of all results in flight");
        end
        repeat (2) tick();
    endtask

    // The scoreboard samples at the falling edge where both handshakes are settled
    always @(negedge clk) begin
        if (!rst) begin
            if (in_valid && in_ready) begin
                exp_q.push_back(alu_ref(in_cmd));
                accepted++;
            end
            if (out_valid && out_ready) begin
                // Every result leaving the DUT counts, matched or not
                results++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Result with tag %h came out with no command in flight",
                             out_res.tag);
                end else begin
                    want = exp_q.pop_front();
                    check_value("out_res.tag", 64'(out_res.tag), 64'(want.tag));
                    check_value("out_res.value", out_res.value, want.value);
                end
            end
        end
    end

    initial begin
        int stall_count;
        int waited;
        logic stalled;
        logic [31:0] r;
        alu_cmd_t c;
        errors = 0;
        accepted = 0;
        results = 0;
        dir_tag = '0;
        rand_ready = 1'b0;
        rst = 1'b1;
        in_cmd = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // Check the idle state after reset and then the latency of one lone command
        @(negedge clk);
        check_value("out_valid after reset", 64'(out_valid), 64'd0);
        check_value("in_ready after reset", 64'(in_ready), 64'd1);
        tick();
        out_ready = 1'b1;
        send_directed(3'd0, 1'b0, 1'b0, 1'b0, 64'd7, 64'd9, '0);
        @(negedge clk);
        check_value("out_valid one cycle after accept", 64'(out_valid), 64'd0);
        @(negedge clk);
        check_value("out_valid two cycles after accept", 64'(out_valid), 64'd1);
        tick();

        // Every function code with and without alt, in both widths and operand forms
        for (int p = 0; p < 4; p++) begin
            for (int w = 0; w < 2; w++) begin
                for (int f = 0; f < 8; f++) begin
                    send_directed(3'(f), 1'b0, w[0], 1'b0, opa_tab[p], opb_tab[p], '0);
                    send_directed(3'(f), 1'b1, w[0], 1'b0, opa_tab[p], opb_tab[p], '0);
                    send_directed(3'(f), 1'b0, w[0], 1'b1, opa_tab[p], 64'd0, imm_tab[p]);
                    send_directed(3'(f), 1'b1, w[0], 1'b1, opa_tab[p], 64'd0, imm_tab[p]);
                end
            end
        end
        drain();

        // Random traffic with gaps on the input and random stalls on the output
        rand_ready = 1'b1;
        for (int i = 0; i < 400; i++) begin
            c = random_cmd();
            r = next_rand();
            repeat (r[1:0]) tick();
            send_cmd(c);
        end
        drain();

        // With the consumer stalled the pipeline fills up and then refuses input
        out_ready = 1'b0;
        c = random_cmd();
        in_cmd = c;
        in_valid = 1'b1;
        stalled = 1'b0;
        stall_count = 0;
        waited = 0;
        while (!stalled) begin
            @(negedge clk);
            if (in_ready)
                stall_count++;
            else
                stalled = 1'b1;
            tick();
            if (!stalled) begin
                c = random_cmd();
                in_cmd = c;
            end
            waited++;
            if (!stalled && waited > TIMEOUT)
                stop_on_timeout("in_ready going low with out_ready low");
        end
        check_value("commands taken while stalled", 64'(stall_count), 64'd6);
        repeat (3) begin
            @(negedge clk);
            check_value("in_ready while full", 64'(in_ready), 64'd0);
            tick();
        end
        out_ready = 1'b1;
        send_cmd(c);
        drain();

        check_value("results returned", 64'(results), 64'(accepted));
        $display("Run complete: %0d errors, %0d results returned for %0d commands",
                 errors, results, accepted);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* risu_alu_pipe.f */
+incdir+source
source/alu_pkg.sv
source/fifo_2d_fwft.sv
source/alu_issue.sv
source/alu_exec.sv
source/alu_pipe_top.sv
test/alu_pipe_chk.sv
test/alu_pipe_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the ALU pipeline testbench with Verilator, runs it and scans the log
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log
bin=alu_pipe_sim

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module alu_pipe_tb -f risu_alu_pipe.f -o "$bin"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./obj_dir/$bin" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The run only counts as passed when the testbench printed its pass line
if grep -qx "TEST PASS" "$log"; then
    echo "Result: simulation passed"
    exit 0
fi
echo "Result: simulation failed"
exit 1
